// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_trigger_serdes
SEED_ARGS ?=
BUILD_DIR ?= obj_dir
FILELIST := sources.f
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal $(SEED_ARGS) \
		--top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: lane_status_collector.sv
`timescale 1ns/100ps
`default_nettype none

module lane_status_collector #(
	parameter int NUM_LANES = 4
) (
	input wire other_clock,
	input wire reset1,
	input wire trig_pkg::lane_done_t [NUM_LANES-1:0] lane_done,
	output logic sync,
	output trig_pkg::word_t led_byte,
	output trig_pkg::count_t words_sent
);

	logic [NUM_LANES-1:0] done_strobe;
	trig_pkg::lane_done_t merged;

	// pick the lane that finished, at most one per cycle
	always_comb begin
		merged = '0;
		for (int i = 0; i < NUM_LANES; i++) begin
			done_strobe[i] = lane_done[i].strobe;
			if (lane_done[i].strobe) begin
				merged = lane_done[i];
			end
		end
	end

	always_ff @(posedge other_clock) begin
		if (reset1) begin
			sync <= 1'b0;
			led_byte <= '0;
			words_sent <= '0;
		end else begin
			// start of sequence marker
			sync <= merged.strobe && (merged.idx == '0);
			if (merged.strobe) begin
				led_byte <= merged.word;
				words_sent <= words_sent + 1'b1;
			end
		end
	end

	// loads go out in distinct cycles and every lane takes the same time,
	// so completions can never collide
	assert property (@(posedge other_clock) disable iff (reset1) $onehot0(done_strobe))
		else $error("two lanes reported done in the same cycle");

endmodule

`default_nettype wire

// File: pattern_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module pattern_sequencer #(
	parameter int NUM_LANES = 4,
	parameter int SELF_PERIOD = 64
) (
	input wire other_clock,
	input wire reset1,
	input wire trigger_in,
	input wire self_triggered,
	input wire [NUM_LANES-1:0] lane_busy,
	output trig_pkg::lane_load_t [NUM_LANES-1:0] lane_load,
	output trig_pkg::count_t dropped_count
);

	localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
	localparam int SELF_W = (SELF_PERIOD > 1) ? $clog2(SELF_PERIOD) : 1;

	logic [1:0] sync_ff;
	logic sync_last;
	logic trig_edge;
	logic [SELF_W-1:0] self_cnt;
	logic self_wrap;
	logic trig;
	logic target_busy;
	trig_pkg::pattern_idx_t token;
	logic [PTR_W-1:0] lane_ptr;
	logic [NUM_LANES-1:0] load_strobe;
	trig_pkg::pattern_idx_t load_idx;
	trig_pkg::word_t load_word;

	function automatic trig_pkg::word_t pattern_word(input trig_pkg::pattern_idx_t idx);
		case (idx)
			2'd0: pattern_word = trig_pkg::PATTERN_0;
			2'd1: pattern_word = trig_pkg::PATTERN_1;
			2'd2: pattern_word = trig_pkg::PATTERN_2;
			default: pattern_word = trig_pkg::PATTERN_3;
		endcase
	endfunction

	assign self_wrap = (self_cnt == SELF_W'(SELF_PERIOD - 1));
	// external edges are ignored in self-triggered mode
	assign trig = self_triggered ? self_wrap : trig_edge;
	// a load still in flight counts as busy, the lane raises busy a cycle later
	assign target_busy = lane_busy[lane_ptr] | load_strobe[lane_ptr];

	// two-flop synchronizer, rising edge registered, plus the free-running counter
	always_ff @(posedge other_clock) begin
		if (reset1) begin
			sync_ff <= '0;
			sync_last <= 1'b0;
			trig_edge <= 1'b0;
			self_cnt <= '0;
		end else begin
			sync_ff <= {sync_ff[0], trigger_in};
			sync_last <= sync_ff[1];
			trig_edge <= sync_ff[1] & ~sync_last;
			self_cnt <= self_wrap ? '0 : self_cnt + 1'b1;
		end
	end

	// dispatch to the lane pointer, or drop when that lane is busy
	always_ff @(posedge other_clock) begin
		if (reset1) begin
			token <= '0;
			lane_ptr <= '0;
			load_strobe <= '0;
			dropped_count <= '0;
		end else begin
			load_strobe <= '0;
			if (trig) begin
				if (target_busy) begin
					dropped_count <= dropped_count + 1'b1;
				end else begin
					load_strobe[lane_ptr] <= 1'b1;
					token <= token + 1'b1;
					lane_ptr <= (lane_ptr == PTR_W'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;
				end
			end
		end
	end

	// only one lane loads per cycle, so the payload is shared
	always_ff @(posedge other_clock) begin
		if (trig && !target_busy) begin
			load_idx <= token;
			load_word <= pattern_word(token);
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			lane_load[i].strobe = load_strobe[i];
			lane_load[i].idx = load_idx;
			lane_load[i].word = load_word;
		end
	end

	// lanes must see their loads one at a time
	assert property (@(posedge other_clock) disable iff (reset1) $onehot0(load_strobe))
		else $error("more than one lane load strobe in one cycle");

endmodule

`default_nettype wire

// File: sources.f
trig_pkg.sv
pattern_sequencer.sv
word_serializer.sv
lane_status_collector.sv
trigger_serdes_top.sv
tb_checker.sv
tb_trigger_serdes.sv

// File: tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker #(
	parameter int NUM_LANES = 4,
	parameter int SELF_PERIOD = 64
) (
	input wire other_clock,
	input wire reset1,
	input wire trigger_in,
	input wire self_triggered,
	input wire [NUM_LANES-1:0] serial_out,
	input wire sync,
	input wire trig_pkg::word_t led_byte,
	input wire trig_pkg::count_t words_sent,
	input wire trig_pkg::count_t dropped_count,
	output int error_count,
	output int model_loads,
	output int model_drops
);

	localparam int WW = trig_pkg::WORD_WIDTH;

	// trigger_in samples, newest in bit 0
	logic [3:0] hist;
	int self_cnt;
	int token;
	int ptr;
	// lane that sees a load strobe this cycle, -1 for none
	int pend_lane;
	trig_pkg::word_t pend_word;
	trig_pkg::pattern_idx_t pend_idx;
	int bits_left [NUM_LANES];
	trig_pkg::word_t lane_word [NUM_LANES];
	trig_pkg::pattern_idx_t lane_idx [NUM_LANES];
	logic done_pend;
	trig_pkg::word_t done_word;
	trig_pkg::pattern_idx_t done_idx;
	logic exp_sync;
	trig_pkg::word_t exp_led;
	trig_pkg::count_t exp_words;
	logic armed = 1'b0;

	initial begin
		error_count = 0;
		model_loads = 0;
		model_drops = 0;
	end

	// sequence 00, 0e, 77, 55
	function automatic trig_pkg::word_t pattern_value(input int n);
		case (n)
			0: return 8'h00;
			1: return 8'h0e;
			2: return 8'h77;
			default: return 8'h55;
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	always @(posedge other_clock) begin : model_step
		logic ext_edge;
		logic self_wrap;
		logic trig;
		logic next_done;
		int next_pend;
		trig_pkg::word_t next_word;
		trig_pkg::pattern_idx_t next_idx;
		armed = 1'b1;
		if (reset1) begin
			hist = '0;
			self_cnt = 0;
			token = 0;
			ptr = 0;
			pend_lane = -1;
			done_pend = 1'b0;
			exp_sync = 1'b0;
			exp_led = '0;
			exp_words = '0;
			model_loads = 0;
			model_drops = 0;
			for (int i = 0; i < NUM_LANES; i++) begin
				bits_left[i] = 0;
			end
		end else begin
			// two synchronizer stages, then one edge stage
			ext_edge = hist[2] & ~hist[3];
			self_wrap = (self_cnt == SELF_PERIOD - 1);
			trig = self_triggered ? self_wrap : ext_edge;
			next_pend = -1;
			next_word = '0;
			next_idx = '0;
			if (trig) begin
				if (bits_left[ptr] > 0 || pend_lane == ptr) begin
					model_drops++;
				end else begin
					next_pend = ptr;
					next_word = pattern_value(token);
					next_idx = 2'(token);
					token = (token + 1) % 4;
					ptr = (ptr + 1) % NUM_LANES;
					model_loads++;
				end
			end
			// collector sees the done from the last cycle
			exp_sync = done_pend && (done_idx == 2'd0);
			if (done_pend) begin
				exp_led = done_word;
				exp_words = exp_words + 16'd1;
			end
			next_done = 1'b0;
			for (int i = 0; i < NUM_LANES; i++) begin
				if (bits_left[i] == 1) begin
					next_done = 1'b1;
					done_word = lane_word[i];
					done_idx = lane_idx[i];
				end
				if (pend_lane == i) begin
					bits_left[i] = WW;
					lane_word[i] = pend_word;
					lane_idx[i] = pend_idx;
				end else if (bits_left[i] > 0) begin
					bits_left[i]--;
				end
			end
			done_pend = next_done;
			pend_lane = next_pend;
			pend_word = next_word;
			pend_idx = next_idx;
			hist = {hist[2:0], trigger_in};
			self_cnt = self_wrap ? 0 : self_cnt + 1;
		end
	end

	// outputs settle at the rising edge, so look at them on the falling one
	always @(negedge other_clock) begin : compare_step
		logic exp_bit;
		if (armed) begin
			for (int i = 0; i < NUM_LANES; i++) begin
				exp_bit = (bits_left[i] > 0) ? lane_word[i][bits_left[i] - 1] : 1'b0;
				compare($sformatf("serial_out[%0d]", i), 32'(serial_out[i]), 32'(exp_bit));
			end
			compare("sync", 32'(sync), 32'(exp_sync));
			compare("led_byte", 32'(led_byte), 32'(exp_led));
			compare("words_sent", 32'(words_sent), 32'(exp_words));
			compare("dropped_count", 32'(dropped_count), 32'(model_drops[15:0]));
		end
	end

endmodule

`default_nettype wire

// File: tb_trigger_serdes.sv
`timescale 1ns/100ps
`default_nettype none

module tb_trigger_serdes #(
	parameter logic [31:0] SEED = 32'hae44_1563
);

	localparam int NUM_LANES = 4;
	localparam int SELF_PERIOD = 64;
	localparam int SPACED_PULSES = 8;
	localparam int RANDOM_PULSES = 12;
	localparam int DENSE_PULSES = 100;
	localparam int SELF_CYCLES = 6 * SELF_PERIOD;
	localparam int DRAIN = 24;
	// longest pulse plus gap is 23 cycles, dense pulses at most 21
	localparam int TIMEOUT_CYCLES = 12 + (SPACED_PULSES + RANDOM_PULSES) * 23
		+ DENSE_PULSES * 21 + SELF_CYCLES + 4 * DRAIN + 100;

	logic other_clock;
	logic reset1;
	logic trigger_in;
	logic self_triggered;
	wire [NUM_LANES-1:0] serial_out;
	wire sync;
	trig_pkg::word_t led_byte;
	trig_pkg::count_t words_sent;
	trig_pkg::count_t dropped_count;
	int checker_errors;
	int model_loads;
	int model_drops;
	logic [31:0] rng_state = SEED;
	int cycle_count = 0;
	int local_fails = 0;
	int phase_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	trigger_serdes_top #(
		.NUM_LANES(NUM_LANES),
		.SELF_PERIOD(SELF_PERIOD)
	) u_dut (
		.other_clock(other_clock),
		.reset1(reset1),
		.trigger_in(trigger_in),
		.self_triggered(self_triggered),
		.serial_out(serial_out),
		.sync(sync),
		.led_byte(led_byte),
		.words_sent(words_sent),
		.dropped_count(dropped_count)
	);

	tb_checker #(
		.NUM_LANES(NUM_LANES),
		.SELF_PERIOD(SELF_PERIOD)
	) u_checker (
		.other_clock(other_clock),
		.reset1(reset1),
		.trigger_in(trigger_in),
		.self_triggered(self_triggered),
		.serial_out(serial_out),
		.sync(sync),
		.led_byte(led_byte),
		.words_sent(words_sent),
		.dropped_count(dropped_count),
		.error_count(checker_errors),
		.model_loads(model_loads),
		.model_drops(model_drops)
	);

	initial begin
		other_clock = 1'b0;
		forever #50 other_clock = ~other_clock;
	end

	always @(posedge other_clock) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic pick(input int lo, input int hi, output int value);
		rng_state = xorshift(rng_state);
		value = lo + int'(rng_state % 32'(hi - lo + 1));
	endtask

	// inputs change 10 ns after the rising edge
	task automatic tick();
		@(posedge other_clock);
		#10;
	endtask

	task automatic send_pulse(input int width, input int gap);
		trigger_in = 1'b1;
		repeat (width) tick();
		trigger_in = 1'b0;
		repeat (gap) tick();
	endtask

	task automatic finish_phase(input string name);
		int total;
		total = checker_errors + local_fails;
		tests_run++;
		if (total != phase_errors) begin
			tests_failed++;
		end
		$display("%s: done, %0d errors", name, total - phase_errors);
		phase_errors = total;
	endtask

	initial begin
		int width;
		int gap;
		int sel;
		int words_before;
		int drops_before;
		trigger_in = 1'b0;
		self_triggered = 1'b0;
		reset1 = 1'b1;
		repeat (8) tick();
		reset1 = 1'b0;
		repeat (4) tick();
		finish_phase("phase 1 reset values");

		// far enough apart that no lane is ever busy
		for (int n = 0; n < SPACED_PULSES; n++) begin
			pick(1, 3, width);
			send_pulse(width, 20);
		end
		repeat (DRAIN) tick();
		if (words_sent !== 16'(SPACED_PULSES)) begin
			local_fails++;
			$display("Mismatch words_sent: got 0x%0h expected 0x%0h", words_sent,
				16'(SPACED_PULSES));
		end
		if (dropped_count !== 16'd0) begin
			local_fails++;
			$display("Mismatch dropped_count: got 0x%0h expected 0x0", dropped_count);
		end
		finish_phase("phase 2 round robin patterns");

		for (int n = 0; n < RANDOM_PULSES; n++) begin
			pick(1, 3, width);
			pick(1, 20, gap);
			send_pulse(width, gap);
		end
		repeat (DRAIN) tick();
		if (words_sent !== 16'(model_loads)) begin
			local_fails++;
			$display("Mismatch words_sent: got 0x%0h expected 0x%0h", words_sent,
				16'(model_loads));
		end
		finish_phase("phase 3 led and sync");

		// mostly back to back, so a lane comes round while still shifting
		drops_before = model_drops;
		for (int n = 0; n < DENSE_PULSES; n++) begin
			pick(0, 3, sel);
			gap = 1;
			if (sel == 0) begin
				pick(1, 20, gap);
			end
			send_pulse(1, gap);
		end
		repeat (DRAIN) tick();
		if (model_drops == drops_before) begin
			local_fails++;
			$display("dense triggers did not lead to a single dropped trigger");
		end
		finish_phase("phase 4 dropped triggers");

		self_triggered = 1'b1;
		words_before = int'(words_sent);
		for (int n = 0; n < SELF_CYCLES; n++) begin
			pick(0, 1, sel);
			trigger_in = (sel != 0);
			tick();
		end
		if (int'(words_sent) - words_before < SELF_CYCLES / SELF_PERIOD - 1) begin
			local_fails++;
			$display("self-triggered mode completed only %0d words",
				int'(words_sent) - words_before);
		end
		trigger_in = 1'b0;
		self_triggered = 1'b0;
		repeat (DRAIN) tick();
		finish_phase("phase 5 self-triggered");

		$display("%0d tests run, %0d failed, %0d mismatches, %0d other errors",
			tests_run, tests_failed, checker_errors, local_fails);
		if (checker_errors + local_fails == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: trig_pkg.sv
`default_nettype none

package trig_pkg;

	// bits in one pattern word
	localparam int WORD_WIDTH = 8;

	// one pattern word as it goes out on a lane
	typedef logic [WORD_WIDTH-1:0] word_t;

	// which of the four patterns a word is
	typedef logic [1:0] pattern_idx_t;

	// drop counter and sent-word counter
	typedef logic [15:0] count_t;

	// the four words of the sequence, each the inverse of its bit pattern
	localparam word_t PATTERN_0 = ~8'b1111_1111;
	localparam word_t PATTERN_1 = ~8'b1111_0001;
	localparam word_t PATTERN_2 = ~8'b1000_1000;
	localparam word_t PATTERN_3 = ~8'b1010_1010;

	// sequencer to lane, strobe high for a single cycle
	typedef struct packed {
		logic         strobe;
		pattern_idx_t idx;
		word_t        word;
	} lane_load_t;

	// lane to collector, strobed in the cycle after the lsb
	typedef struct packed {
		logic         strobe;
		pattern_idx_t idx;
		word_t        word;
	} lane_done_t;

endpackage

`default_nettype wire

// File: trigger_serdes_top.sv
`timescale 1ns/100ps
`default_nettype none

module trigger_serdes_top #(
	parameter int NUM_LANES = 4,
	parameter int SELF_PERIOD = 64
) (
	input wire other_clock,
	input wire reset1,
	input wire trigger_in,
	input wire self_triggered,
	output wire [NUM_LANES-1:0] serial_out,
	output wire sync,
	output trig_pkg::word_t led_byte,
	output trig_pkg::count_t words_sent,
	output trig_pkg::count_t dropped_count
);

	trig_pkg::lane_load_t [NUM_LANES-1:0] lane_load;
	trig_pkg::lane_done_t [NUM_LANES-1:0] lane_done;
	wire [NUM_LANES-1:0] lane_busy;

	pattern_sequencer #(
		.NUM_LANES(NUM_LANES),
		.SELF_PERIOD(SELF_PERIOD)
	) u_sequencer (
		.other_clock(other_clock),
		.reset1(reset1),
		.trigger_in(trigger_in),
		.self_triggered(self_triggered),
		.lane_busy(lane_busy),
		.lane_load(lane_load),
		.dropped_count(dropped_count)
	);

	// one serializer per output lane
	genvar g;
	generate
		for (g = 0; g < NUM_LANES; g++) begin : g_lane
			word_serializer u_lane (
				.other_clock(other_clock),
				.reset1(reset1),
				.load(lane_load[g]),
				.serial_out(serial_out[g]),
				.busy(lane_busy[g]),
				.done(lane_done[g])
			);
		end
	endgenerate

	lane_status_collector #(
		.NUM_LANES(NUM_LANES)
	) u_collector (
		.other_clock(other_clock),
		.reset1(reset1),
		.lane_done(lane_done),
		.sync(sync),
		.led_byte(led_byte),
		.words_sent(words_sent)
	);

endmodule

`default_nettype wire

// File: word_serializer.sv
`timescale 1ns/100ps
`default_nettype none

module word_serializer (
	input wire other_clock,
	input wire reset1,
	input wire trig_pkg::lane_load_t load,
	output logic serial_out,
	output logic busy,
	output trig_pkg::lane_done_t done
);

	localparam int MSB = trig_pkg::WORD_WIDTH - 1;
	localparam int CNT_W = $clog2(trig_pkg::WORD_WIDTH + 1);

	trig_pkg::word_t shift_reg;
	trig_pkg::pattern_idx_t idx_q;
	logic [CNT_W-1:0] bits_left;
	logic done_strobe;

	assign busy = (bits_left != '0);
	// line stays low while the lane is idle
	assign serial_out = busy & shift_reg[MSB];

	always_ff @(posedge other_clock) begin
		if (reset1) begin
			bits_left <= '0;
			done_strobe <= 1'b0;
		end else begin
			// last bit is on the line now
			done_strobe <= (bits_left == CNT_W'(1));
			if (load.strobe) begin
				bits_left <= CNT_W'(trig_pkg::WORD_WIDTH);
			end else if (busy) begin
				bits_left <= bits_left - 1'b1;
			end
		end
	end

	// rotate rather than shift, after a full word the original is back in place
	always_ff @(posedge other_clock) begin
		if (load.strobe) begin
			shift_reg <= load.word;
			idx_q <= load.idx;
		end else if (busy) begin
			shift_reg <= {shift_reg[MSB-1:0], shift_reg[MSB]};
		end
	end

	always_comb begin
		done.strobe = done_strobe;
		done.idx = idx_q;
		done.word = shift_reg;
	end

	// sequencer must never load a lane that is still shifting
	assert property (@(posedge other_clock) disable iff (reset1) load.strobe |-> !busy)
		else $error("load strobe while lane busy");

endmodule

`default_nettype wire
